/* verilog/ucpu_pkg.sv */
package ucpu_pkg;

    localparam int         UCODE_STEP_W = 3;      // up to 8 steps per routine
    localparam logic [7:0] IRQ_VEC      = 8'hf0;  // single fixed interrupt vector
    localparam logic [7:0] RESET_PC     = 8'h00;

    // one byte per opcode, operand byte follows for _IMM, _MEM, JMP and JZ
    typedef enum logic [7:0] {
        NOP     = 8'h00,
        LDA_IMM = 8'h01,
        LDA_MEM = 8'h02,
        STA_MEM = 8'h03,
        ADD_IMM = 8'h04,
        ADD_MEM = 8'h05,
        SUB_IMM = 8'h06,
        AND_IMM = 8'h07,
        XOR_IMM = 8'h08,
        JMP     = 8'h09,
        JZ      = 8'h0a,
        EI      = 8'h0b,
        DI      = 8'h0c,
        RTI     = 8'h0d,
        HLT     = 8'h0e
    } opcode_e;

    // microcode routines, the first three are not reached from an opcode directly
    typedef enum logic [3:0] {
        CAT_RESET,   // doubles as the opcode fetch routine
        CAT_IRQ,
        CAT_BUSERR,
        CAT_NOP,
        CAT_ALU_IMM,
        CAT_ALU_MEM,
        CAT_STORE,
        CAT_JMP,
        CAT_JZ,
        CAT_EI,
        CAT_DI,
        CAT_RTI,
        CAT_HALT
    } opcat_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic    mem_rd;
        logic    mem_wr;
        logic    addr_opnd;  // address from operand latch, else PC
        logic    ld_opnd;
        logic    ld_a;
        logic    pc_inc;
        logic    pc_load;
        logic    pc_load_z;  // load only if Z set
        alu_op_e alu_op;
        logic    ie_set;
        logic    ie_clr;
        logic    irq_entry;
        logic    rti;
        logic    ni;         // next instruction
        logic    halt;
    } ucode_word_t;

    typedef struct packed {
        logic       req;
        logic       we;
        logic [7:0] addr;
        logic [7:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] rdata;
    } bus_rsp_t;

endpackage

/* verilog/ucpu_alu.sv */
module ucpu_alu import ucpu_pkg::*; (
    input  alu_op_e    op,
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] y,
    output logic       zero
);

    // wrap-around arithmetic, carry is dropped
    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_XOR: y = a ^ b;
            default: y = b;  // pass, used by loads
        endcase
    end

    assign zero = (y == 8'h00);

endmodule

/* verilog/ucpu_ucode.sv */
module ucpu_ucode import ucpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        irq,
    input  logic        ie,
    input  logic [7:0]  rd_data,
    input  logic        mem_busy,
    input  logic        mem_done,
    output ucode_word_t uc,
    output logic        halted
);

    opcat_e                  cat;       // routine being executed
    logic [UCODE_STEP_W-1:0] step;
    alu_op_e                 alu_sel;   // ALU operation of the current opcode
    opcat_e                  op_cat;
    alu_op_e                 op_alu;

    // opcode categorization, looked at only when a fetch completes
    always_comb begin
        op_alu = ALU_PASS;
        case (rd_data)
            NOP:     op_cat = CAT_NOP;
            LDA_IMM: op_cat = CAT_ALU_IMM;
            LDA_MEM: op_cat = CAT_ALU_MEM;
            STA_MEM: op_cat = CAT_STORE;
            ADD_IMM: begin
                op_cat = CAT_ALU_IMM;
                op_alu = ALU_ADD;
            end
            ADD_MEM: begin
                op_cat = CAT_ALU_MEM;
                op_alu = ALU_ADD;
            end
            SUB_IMM: begin
                op_cat = CAT_ALU_IMM;
                op_alu = ALU_SUB;
            end
            AND_IMM: begin
                op_cat = CAT_ALU_IMM;
                op_alu = ALU_AND;
            end
            XOR_IMM: begin
                op_cat = CAT_ALU_IMM;
                op_alu = ALU_XOR;
            end
            JMP:     op_cat = CAT_JMP;
            JZ:      op_cat = CAT_JZ;
            EI:      op_cat = CAT_EI;
            DI:      op_cat = CAT_DI;
            RTI:     op_cat = CAT_RTI;
            HLT:     op_cat = CAT_HALT;
            default: op_cat = CAT_BUSERR;  // unknown opcode stops the cpu
        endcase
    end

    // microcode table, indexed by routine and step
    always_comb begin
        uc = '0;
        case ({cat, step})
            {CAT_RESET, 3'd0}: begin  // opcode fetch
                uc.mem_rd = 1'b1;
                uc.pc_inc = 1'b1;
            end
            // operand byte after the opcode
            {CAT_ALU_IMM, 3'd0},
            {CAT_ALU_MEM, 3'd0},
            {CAT_STORE, 3'd0},
            {CAT_JMP, 3'd0},
            {CAT_JZ, 3'd0}: begin
                uc.mem_rd  = 1'b1;
                uc.pc_inc  = 1'b1;
                uc.ld_opnd = 1'b1;
            end
            {CAT_ALU_MEM, 3'd1}: begin  // memory data replaces the address
                uc.mem_rd    = 1'b1;
                uc.addr_opnd = 1'b1;
                uc.ld_opnd   = 1'b1;
            end
            {CAT_ALU_IMM, 3'd1},
            {CAT_ALU_MEM, 3'd2}: begin
                uc.ld_a = 1'b1;
                uc.ni   = 1'b1;
            end
            {CAT_STORE, 3'd1}: begin
                uc.mem_wr    = 1'b1;
                uc.addr_opnd = 1'b1;
                uc.ni        = 1'b1;
            end
            {CAT_JMP, 3'd1}: begin
                uc.pc_load = 1'b1;
                uc.ni      = 1'b1;
            end
            {CAT_JZ, 3'd1}: begin
                uc.pc_load_z = 1'b1;
                uc.ni        = 1'b1;
            end
            {CAT_IRQ, 3'd0}: uc.irq_entry = 1'b1;
            {CAT_EI, 3'd0}:  uc.ie_set    = 1'b1;
            {CAT_DI, 3'd0}:  uc.ie_clr    = 1'b1;
            {CAT_RTI, 3'd0}: begin
                uc.rti    = 1'b1;
                uc.ie_set = 1'b1;  // handler entry cleared it
            end
            // flag changes settle before the boundary looks at IE
            {CAT_NOP, 3'd0},
            {CAT_IRQ, 3'd1},
            {CAT_EI, 3'd1},
            {CAT_DI, 3'd1},
            {CAT_RTI, 3'd1}: uc.ni = 1'b1;
            {CAT_HALT, 3'd0},
            {CAT_BUSERR, 3'd0}: uc.halt = 1'b1;
            default: uc.halt = 1'b1;  // unused slot, trap
        endcase
        uc.alu_op = alu_sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cat     <= CAT_RESET;
            step    <= '0;
            alu_sel <= ALU_PASS;
            halted  <= 1'b0;
        end else if (uc.halt) begin
            halted <= 1'b1;  // frozen from here on
        end else if (cat == CAT_RESET && mem_done) begin
            cat     <= op_cat;
            alu_sel <= op_alu;
            step    <= '0;
        end else if (!mem_busy) begin
            if (uc.ni) begin
                // interrupt only taken at an instruction boundary
                cat  <= (irq && ie) ? CAT_IRQ : CAT_RESET;
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

/* verilog/ucpu_datapath.sv */
module ucpu_datapath import ucpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ucode_word_t uc,
    input  logic [7:0]  rd_data,
    input  logic        mem_done,
    output logic [7:0]  addr,
    output logic [7:0]  wdata,
    output logic        ie
);

    logic [7:0] a;
    logic [7:0] pc;
    logic [7:0] opnd;   // operand byte, later the memory data
    logic [7:0] epc;
    logic [7:0] alu_y;
    logic       z;
    logic       alu_zero;
    logic       step_end;

    // a memory step only takes effect when its transaction completes
    assign step_end = !(uc.mem_rd || uc.mem_wr) || mem_done;

    assign addr  = uc.addr_opnd ? opnd : pc;
    assign wdata = a;  // STA is the only store

    ucpu_alu alu0 (
        .op   (uc.alu_op),
        .a    (a),
        .b    (opnd),
        .y    (alu_y),
        .zero (alu_zero)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            ie <= 1'b0;
            a  <= 8'h00;
            z  <= 1'b0;
        end else if (step_end) begin
            if (uc.pc_inc) pc <= pc + 8'd1;
            if (uc.pc_load || (uc.pc_load_z && z)) pc <= opnd;
            if (uc.irq_entry) pc <= IRQ_VEC;
            if (uc.rti) pc <= epc;
            if (uc.ld_a) begin
                a <= alu_y;
                z <= alu_zero;
            end
            if (uc.ie_set) ie <= 1'b1;
            if (uc.ie_clr || uc.irq_entry) ie <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (step_end) begin
            if (uc.ld_opnd) opnd <= rd_data;
            if (uc.irq_entry) epc <= pc;  // return address for RTI
        end
    end

endmodule

/* verilog/ucpu_membus.sv */
module ucpu_membus import ucpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ucode_word_t uc,
    input  logic [7:0]  addr,
    input  logic [7:0]  wdata,
    output bus_req_t    bus_o,
    input  bus_rsp_t    bus_i,
    output logic [7:0]  rd_data,
    output logic        mem_busy,
    output logic        mem_done
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE,
        DONE
    } state_e;

    state_e     state;
    logic [7:0] rd_q;
    logic       access;

    assign access   = uc.mem_rd || uc.mem_wr;
    assign mem_done = (state == DONE);
    assign mem_busy = access && !mem_done;
    assign rd_data  = rd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            bus_o <= '0;
        end else begin
            case (state)
                IDLE: if (access) begin
                    bus_o.req   <= 1'b1;
                    bus_o.we    <= uc.mem_wr;
                    bus_o.addr  <= addr;   // held until the handshake ends
                    bus_o.wdata <= wdata;
                    state       <= REQ;
                end
                REQ: if (bus_i.ack) begin
                    bus_o.req <= 1'b0;
                    state     <= RELEASE;
                end
                RELEASE: if (!bus_i.ack) state <= DONE;  // ack low, slot free
                default: begin
                    bus_o.we <= 1'b0;
                    state    <= IDLE;
                end
            endcase
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (state == REQ && bus_i.ack) rd_q <= bus_i.rdata;
    end

endmodule

/* verilog/ucpu_top.sv */
module ucpu_top import ucpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     irq,
    output bus_req_t bus_o,
    input  bus_rsp_t bus_i,
    output logic     halted
);

    ucode_word_t uc;
    logic [7:0]  rd_data;
    logic [7:0]  addr;
    logic [7:0]  wdata;
    logic        mem_busy;
    logic        mem_done;
    logic        ie;

    ucpu_ucode ucode0 (
        .clk      (clk),
        .rst      (rst),
        .irq      (irq),
        .ie       (ie),
        .rd_data  (rd_data),
        .mem_busy (mem_busy),
        .mem_done (mem_done),
        .uc       (uc),
        .halted   (halted)
    );

    ucpu_datapath datapath0 (
        .clk      (clk),
        .rst      (rst),
        .uc       (uc),
        .rd_data  (rd_data),
        .mem_done (mem_done),
        .addr     (addr),
        .wdata    (wdata),
        .ie       (ie)
    );

    ucpu_membus membus0 (
        .clk      (clk),
        .rst      (rst),
        .uc       (uc),
        .addr     (addr),
        .wdata    (wdata),
        .bus_o    (bus_o),
        .bus_i    (bus_i),
        .rd_data  (rd_data),
        .mem_busy (mem_busy),
        .mem_done (mem_done)
    );

endmodule

/* testbench/ucpu_assertions.sv */
module ucpu_assertions import ucpu_pkg::*; (
    input logic     clk,
    input logic     rst,
    input bus_req_t bus_o,
    input bus_rsp_t bus_i
);

    // four-phase rule, a new request waits for ack low
    req_waits_ack_low: assert property (
        @(posedge clk) disable iff (rst) $rose(bus_o.req) |-> !bus_i.ack
    ) else $error("req rose while ack was high");

    // request fields frozen during the handshake
    req_fields_hold: assert property (
        @(posedge clk) disable iff (rst)
        (bus_o.req && $past(bus_o.req)) |->
            ($stable(bus_o.addr) && $stable(bus_o.we) && $stable(bus_o.wdata))
    ) else $error("addr, we or wdata changed while req was high");

    req_low_after_reset: assert property (
        @(posedge clk) rst |=> !bus_o.req
    ) else $error("req high in the cycle after reset");

endmodule

/* testbench/ucpu_tb.sv */
module ucpu_tb import ucpu_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       irq;
    bus_req_t   bus_o;
    bus_rsp_t   bus_i;
    logic       halted;
    logic [7:0] mem [0:255];       // memory behind the responder
    logic [7:0] mmem [0:255];      // model copy
    logic       exp_we [0:1023];
    logic [7:0] exp_addr [0:1023];
    logic [7:0] exp_data [0:1023];
    int         ev_raise [0:1];    // access index where irq rises
    int         ev_drop [0:1];     // access index where irq falls
    int         exp_n, acc_idx, ev_n, errors, failed, ntests, base;
    int         seed, r, rsp_st, rsp_cnt;
    logic       req_q, seen_vec, first_we, hung;
    logic [7:0] first_addr;

    ucpu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .irq    (irq),
        .bus_o  (bus_o),
        .bus_i  (bus_i),
        .halted (halted)
    );

    bind ucpu_top ucpu_assertions asrt0 (
        .clk   (clk),
        .rst   (rst),
        .bus_o (bus_o),
        .bus_i (bus_i)
    );

    always #50 clk = ~clk;

    task put_byte(inout int p, input logic [7:0] b);
        mem[p[7:0]] = b;
        p = p + 1;
    endtask

    task build_program(input bit bad_end);
        int pc, k, gap, v;
        for (k = 0; k < 256; k++) mem[k] = 8'(k * 37 + 11);
        pc = 0;
        put_byte(pc, ADD_IMM);  // operand instruction with IE clear
        put_byte(pc, 8'h11);
        put_byte(pc, EI);
        while (pc < 104) begin
            r = $random(seed);
            v = $random(seed);
            gap = 1 + ((r >> 4) & 3);
            case (r & 15)
                0: put_byte(pc, NOP);
                1, 2: begin
                    put_byte(pc, LDA_IMM);
                    put_byte(pc, 8'(v));
                end
                3: begin
                    put_byte(pc, LDA_MEM);
                    put_byte(pc, 8'(128 + (v & 127) % 112));
                end
                4: begin
                    put_byte(pc, STA_MEM);
                    put_byte(pc, 8'(128 + (v & 127) % 112));
                end
                5: begin
                    put_byte(pc, ADD_IMM);
                    put_byte(pc, 8'(v));
                end
                6: begin
                    put_byte(pc, ADD_MEM);
                    put_byte(pc, 8'(128 + (v & 127) % 112));
                end
                7: begin
                    put_byte(pc, SUB_IMM);
                    put_byte(pc, 8'(v));
                end
                8: begin
                    put_byte(pc, AND_IMM);
                    put_byte(pc, 8'(v));
                end
                9: begin
                    put_byte(pc, XOR_IMM);
                    put_byte(pc, 8'(v));
                end
                10: put_byte(pc, EI);
                11: put_byte(pc, DI);
                12: begin  // skipped bytes would trap if executed
                    put_byte(pc, JMP);
                    put_byte(pc, 8'(pc + 1 + gap));
                    repeat (gap) put_byte(pc, 8'hff);
                end
                13, 14: begin  // nop fill keeps the untaken path valid
                    put_byte(pc, JZ);
                    put_byte(pc, 8'(pc + 1 + gap));
                    repeat (gap) put_byte(pc, NOP);
                end
                default: begin  // forces Z
                    put_byte(pc, AND_IMM);
                    put_byte(pc, 8'h00);
                end
            endcase
        end
        put_byte(pc, bad_end ? 8'hff : 8'(HLT));
        pc = 240;  // handler at IRQ_VEC
        put_byte(pc, XOR_IMM);
        put_byte(pc, 8'h3c);
        put_byte(pc, STA_MEM);
        put_byte(pc, 8'he8);
        put_byte(pc, RTI);
    endtask

    task expect_access(input logic we, input logic [7:0] a, input logic [7:0] d);
        exp_we[exp_n] = we;
        exp_addr[exp_n] = a;
        exp_data[exp_n] = d;
        exp_n = exp_n + 1;
    endtask

    // ISA model that builds the expected bus accesses and the irq windows
    task run_model(input bit use_irq);
        logic [7:0] pc, a, epc, op, opnd, d;
        logic       z, ie, irq_now, done_set, done_clr, drop_wait;
        int         k, steps, opnd_idx;
        for (k = 0; k < 256; k++) mmem[k] = mem[k];
        pc = RESET_PC;
        a = 8'h00;
        epc = 8'h00;
        z = 1'b0;
        ie = 1'b0;
        done_set = 1'b0;
        done_clr = 1'b0;
        drop_wait = 1'b0;
        exp_n = 0;
        ev_n = 0;
        for (steps = 0; steps < 1000; steps++) begin
            if (drop_wait) begin
                ev_drop[ev_n - 1] = exp_n;  // irq released at the next fetch
                drop_wait = 1'b0;
            end
            expect_access(1'b0, pc, 8'h00);
            op = mmem[pc];
            pc = pc + 8'd1;
            irq_now = 1'b0;
            if (op >= LDA_IMM && op <= JZ) begin
                opnd_idx = exp_n;
                expect_access(1'b0, pc, 8'h00);
                opnd = mmem[pc];
                pc = pc + 8'd1;
                if (use_irq && ((ie && !done_set) || (!ie && !done_clr))) begin
                    ev_raise[ev_n] = opnd_idx;
                    ev_n = ev_n + 1;
                    drop_wait = 1'b1;
                    irq_now = 1'b1;
                    if (ie) done_set = 1'b1;
                    else done_clr = 1'b1;
                end
            end
            case (op)
                NOP: ;
                LDA_IMM: a = opnd;
                ADD_IMM: a = a + opnd;
                SUB_IMM: a = a - opnd;
                AND_IMM: a = a & opnd;
                XOR_IMM: a = a ^ opnd;
                LDA_MEM, ADD_MEM: begin
                    expect_access(1'b0, opnd, 8'h00);
                    d = mmem[opnd];
                    a = (op == LDA_MEM) ? d : a + d;
                end
                STA_MEM: begin
                    expect_access(1'b1, opnd, a);
                    mmem[opnd] = a;
                end
                JMP: pc = opnd;
                JZ: if (z) pc = opnd;
                EI: ie = 1'b1;
                DI: ie = 1'b0;
                RTI: begin
                    pc = epc;
                    ie = 1'b1;
                end
                default: return;  // HLT and unknown opcodes
            endcase
            if (op >= LDA_IMM && op <= XOR_IMM && op != STA_MEM) z = (a == 8'h00);
            if (irq_now && ie) begin
                epc = pc;
                ie = 1'b0;
                pc = IRQ_VEC;
            end
        end
    endtask

    task check_byte(input string sig, input logic [7:0] expv, input logic [7:0] act);
        if (expv !== act) begin
            $display("CHECK FAILED time %0t %s expected %h actual %h",
                $time, sig, expv, act);
            errors = errors + 1;
        end
    endtask

    task report_test(input string name);
        ntests = ntests + 1;
        if (errors == base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - base);
            failed = failed + 1;
        end
        base = errors;
    endtask

    task wait_halted();
        int cyc;
        cyc = 0;
        while (!halted && cyc < 20000) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        if (!halted) begin
            $display("timeout: the cpu never raised halted");
            errors = errors + 1;
            hung = 1'b1;
        end
    endtask

    task check_quiet_after_halt();
        int held;
        held = acc_idx;
        repeat (50) @(posedge clk);
        if (acc_idx != held) begin
            $display("error: bus request seen after halted at time %0t", $time);
            errors = errors + 1;
        end
    endtask

    // memory responder with 0 to 3 extra cycles before ack
    always @(posedge clk) begin
        if (rst) begin
            bus_i <= '0;
            rsp_st = 0;
        end else begin
            case (rsp_st)
                0: if (bus_o.req) begin
                    rsp_cnt = $random(seed) & 3;
                    rsp_st = 1;
                end
                1: if (rsp_cnt == 0) begin
                    bus_i.ack <= 1'b1;
                    bus_i.rdata <= mem[bus_o.addr];
                    if (bus_o.we) mem[bus_o.addr] = bus_o.wdata;
                    rsp_st = 2;
                end else begin
                    rsp_cnt = rsp_cnt - 1;
                end
                default: if (!bus_o.req) begin
                    bus_i.ack <= 1'b0;
                    rsp_st = 0;
                end
            endcase
        end
    end

    // bus monitor that compares each new request and drives irq
    always @(posedge clk) begin
        if (rst) begin
            if (bus_o.req) begin
                $display("error: req high during reset at time %0t", $time);
                errors = errors + 1;
            end
            req_q <= 1'b0;
            irq <= 1'b0;
            acc_idx = 0;
            seen_vec = 1'b0;
        end else begin
            req_q <= bus_o.req;
            if (bus_o.req && !req_q) begin
                if (acc_idx == 0) begin
                    first_we = bus_o.we;
                    first_addr = bus_o.addr;
                end
                if (acc_idx >= exp_n) begin
                    $display("error: unexpected bus request at time %0t addr %h",
                        $time, bus_o.addr);
                    errors = errors + 1;
                end else begin
                    check_byte("bus_o.we", {7'd0, exp_we[acc_idx]}, {7'd0, bus_o.we});
                    check_byte("bus_o.addr", exp_addr[acc_idx], bus_o.addr);
                    if (exp_we[acc_idx]) begin
                        check_byte("bus_o.wdata", exp_data[acc_idx], bus_o.wdata);
                    end
                    if (!bus_o.we && bus_o.addr == IRQ_VEC) seen_vec = 1'b1;
                end
                for (int k = 0; k < ev_n; k++) begin
                    if (acc_idx == ev_raise[k]) irq <= 1'b1;
                    if (acc_idx == ev_drop[k]) irq <= 1'b0;
                end
                acc_idx = acc_idx + 1;
            end
        end
    end

    initial begin
        int cyc;
        seed = 32'hbbaa;
        clk = 1'b0;
        rst = 1'b1;
        irq = 1'b0;
        bus_i = '0;
        errors = 0;
        failed = 0;
        ntests = 0;
        base = 0;
        exp_n = 0;
        ev_n = 0;
        hung = 1'b0;
        build_program(1'b0);
        run_model(1'b1);
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        cyc = 0;
        while (acc_idx == 0 && cyc < 100) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        if (acc_idx == 0) begin
            $display("timeout: no bus request after reset");
            errors = errors + 1;
            hung = 1'b1;
        end else begin
            check_byte("bus_o.we", 8'h00, {7'd0, first_we});
            check_byte("bus_o.addr", RESET_PC, first_addr);
            report_test("reset and first fetch");
            wait_halted();
        end

        if (!hung) begin
            if (acc_idx != exp_n) begin
                $display("error: %0d bus accesses seen, model expects %0d", acc_idx, exp_n);
                errors = errors + 1;
            end
            report_test("access sequence and stores");
            if (ev_n != 2 || !seen_vec) begin
                $display("error: interrupt entry or ignored irq not exercised");
                errors = errors + 1;
            end
            report_test("interrupt");
            check_quiet_after_halt();
            report_test("halt");

            // second run ends in an unknown opcode
            @(posedge clk);
            rst <= 1'b1;
            build_program(1'b1);
            run_model(1'b0);
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            wait_halted();
        end

        if (!hung) begin
            check_quiet_after_halt();
            if (acc_idx != exp_n) begin
                $display("error: %0d bus accesses seen, model expects %0d", acc_idx, exp_n);
                errors = errors + 1;
            end
            report_test("unknown opcode halt");
        end

        $display("%0d tests, %0d failed, %0d check errors", ntests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* ucpu_top.f */
verilog/ucpu_pkg.sv
verilog/ucpu_alu.sv
verilog/ucpu_ucode.sv
verilog/ucpu_datapath.sv
verilog/ucpu_membus.sv
verilog/ucpu_top.sv
testbench/ucpu_assertions.sv
testbench/ucpu_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module ucpu_tb -f ucpu_top.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vucpu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
